// ==== mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

	// Instruction field widths
	localparam int wordW = 32;
	localparam int opW = 6;
	localparam int funcW = 6;
	localparam int immW = 16;

	typedef logic [wordW-1:0] wordT;
	typedef logic [opW-1:0] opcodeT;
	typedef logic [funcW-1:0] funcT;
	typedef logic [immW-1:0] imm16T;

	//////////////////////////////
	// Opcodes
	localparam opcodeT opR = 6'b000000; // Special, decoded by func
	localparam opcodeT opJ = 6'b000010;
	localparam opcodeT opJal = 6'b000011;
	localparam opcodeT opBeq = 6'b000100;
	localparam opcodeT opBne = 6'b000101;
	localparam opcodeT opAddi = 6'b001000;
	localparam opcodeT opAndi = 6'b001100;
	localparam opcodeT opOri = 6'b001101;
	localparam opcodeT opLui = 6'b001111;
	localparam opcodeT opLb = 6'b100000;
	localparam opcodeT opLh = 6'b100001;
	localparam opcodeT opLw = 6'b100011;
	localparam opcodeT opSb = 6'b101000;
	localparam opcodeT opSh = 6'b101001;
	localparam opcodeT opSw = 6'b101011;

	//////////////////////////////
	// Function field of R-type
	localparam funcT fnJr = 6'b001000;
	localparam funcT fnMovz = 6'b001010;
	localparam funcT fnMfhi = 6'b010000;
	localparam funcT fnMthi = 6'b010001;
	localparam funcT fnMflo = 6'b010010;
	localparam funcT fnMtlo = 6'b010011;
	localparam funcT fnMult = 6'b011000;
	localparam funcT fnMultu = 6'b011001;
	localparam funcT fnDiv = 6'b011010;
	localparam funcT fnDivu = 6'b011011;
	localparam funcT fnAdd = 6'b100000;
	localparam funcT fnSub = 6'b100010;
	localparam funcT fnAnd = 6'b100100;
	localparam funcT fnOr = 6'b100101;
	localparam funcT fnSlt = 6'b101010;
	localparam funcT fnSltu = 6'b101011;

endpackage

`default_nettype wire

// ==== ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	// ALU operation, consumed in E
	typedef enum logic [2:0] {
		aluAdd = 3'b000,
		aluSub = 3'b001,
		aluOr = 3'b010,
		aluAnd = 3'b011,
		aluLui = 3'b100,
		aluSlt = 3'b101,
		aluSltu = 3'b110,
		aluPassA = 3'b111 // movz moves rs through
	} aluCtrlT;

	typedef enum logic [3:0] {
		mduNone = 4'd0,
		mduMult = 4'd1,
		mduMultu = 4'd2,
		mduDiv = 4'd3,
		mduDivu = 4'd4,
		mduMfhi = 4'd5,
		mduMflo = 4'd6,
		mduMthi = 4'd7,
		mduMtlo = 4'd8
	} mduOpT;

	// Next PC select, consumed in D
	typedef enum logic [2:0] {
		npcSeq = 3'b000,
		npcJump = 3'b001, // j and jal
		npcBranch = 3'b010,
		npcJumpReg = 3'b011
	} npcOpT;

	typedef enum logic [2:0] {
		cmpEq = 3'b000,
		cmpNe = 3'b001,
		cmpRtZero = 3'b111
	} cmpOpT;

	typedef enum logic [1:0] {dstRt = 2'b00, dstRd = 2'b01, dstRa = 2'b10} regDstT;
	typedef enum logic [1:0] {wbAlu = 2'b00, wbMem = 2'b01, wbPc = 2'b10} memtoRegT;

	// Store width for the M stage
	typedef enum logic [1:0] {beWord = 2'b00, beHalf = 2'b01, beByte = 2'b10, beNone = 2'b11} beOpT;
	// Load extension for WB
	typedef enum logic [2:0] {deWord = 3'b000, deByte = 3'b010, deHalf = 3'b100, deNone = 3'b111} deOpT;

	typedef enum logic {mduIdle = 1'b0, mduRun = 1'b1} mduStateT;

endpackage

`default_nettype wire

// ==== ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module ctrl (
	input wire mipsIsaPkg::opcodeT op,
	input wire mipsIsaPkg::funcT func,
	input wire logic judge,
	output ctrlPkg::regDstT regDst, // WB
	output logic regWrite, // WB
	output logic extOp, // D
	output logic aluSrc, // E
	output ctrlPkg::aluCtrlT aluCtrl, // E
	output logic memWrite, // M
	output ctrlPkg::memtoRegT memtoReg, // WB
	output ctrlPkg::npcOpT npcOp, // D
	output ctrlPkg::cmpOpT cmpOp,
	output ctrlPkg::beOpT beOp, // M
	output ctrlPkg::deOpT deOp,
	output logic start,
	output logic selMdu,
	output ctrlPkg::mduOpT mduOp
);
	import mipsIsaPkg::*;
	import ctrlPkg::*;

	logic rType;
	logic isAdd, isSub, isAnd, isOr, isSlt, isSltu, isJr, isMovz;
	logic isMult, isMultu, isDiv, isDivu, isMfhi, isMflo, isMthi, isMtlo;
	logic isLw, isLb, isLh, isSw, isSb, isSh;
	logic isBeq, isBne, isOri, isAddi, isAndi, isLui, isJ, isJal;
	logic rAlu, isLoad, isStore;

	//////////////////////////////
	// Instruction recognition
	assign rType = (op == opR);
	assign isAdd = rType && (func == fnAdd);
	assign isSub = rType && (func == fnSub);
	assign isAnd = rType && (func == fnAnd);
	assign isOr = rType && (func == fnOr);
	assign isSlt = rType && (func == fnSlt);
	assign isSltu = rType && (func == fnSltu);
	assign isJr = rType && (func == fnJr);
	assign isMovz = rType && (func == fnMovz);
	assign isMult = rType && (func == fnMult);
	assign isMultu = rType && (func == fnMultu);
	assign isDiv = rType && (func == fnDiv);
	assign isDivu = rType && (func == fnDivu);
	assign isMfhi = rType && (func == fnMfhi);
	assign isMflo = rType && (func == fnMflo);
	assign isMthi = rType && (func == fnMthi);
	assign isMtlo = rType && (func == fnMtlo);

	assign isLw = (op == opLw);
	assign isLb = (op == opLb);
	assign isLh = (op == opLh);
	assign isSw = (op == opSw);
	assign isSb = (op == opSb);
	assign isSh = (op == opSh);
	assign isBeq = (op == opBeq);
	assign isBne = (op == opBne);
	assign isOri = (op == opOri);
	assign isAddi = (op == opAddi);
	assign isAndi = (op == opAndi);
	assign isLui = (op == opLui);
	assign isJ = (op == opJ);
	assign isJal = (op == opJal);

	assign rAlu = isAdd | isSub | isAnd | isOr | isSlt | isSltu;
	assign isLoad = isLw | isLb | isLh;
	assign isStore = isSw | isSb | isSh;

	//////////////////////////////
	// Control fields
	assign regWrite = rAlu | isLoad | isOri | isAddi | isAndi | isLui | isJal
		| isMfhi | isMflo | (isMovz & judge); // movz only when rt is zero
	assign extOp = isLoad | isStore | isAddi; // Sign extend
	assign aluSrc = isLoad | isStore | isOri | isAddi | isAndi | isLui;
	assign memWrite = isStore;
	assign start = isMult | isMultu | isDiv | isDivu;
	assign selMdu = isMfhi | isMflo;

	always_comb begin
		regDst = dstRt;
		if (isJal) regDst = dstRa;
		else if (rAlu | isMfhi | isMflo | isMovz) regDst = dstRd;
	end

	always_comb begin
		aluCtrl = aluAdd; // Loads, stores, addi
		if (isSub) aluCtrl = aluSub;
		else if (isOr | isOri) aluCtrl = aluOr;
		else if (isAnd | isAndi) aluCtrl = aluAnd;
		else if (isLui) aluCtrl = aluLui;
		else if (isSlt) aluCtrl = aluSlt;
		else if (isSltu) aluCtrl = aluSltu;
		else if (isMovz) aluCtrl = aluPassA;
	end

	always_comb begin
		memtoReg = wbAlu;
		if (isLoad) memtoReg = wbMem;
		else if (isJal) memtoReg = wbPc; // Link address
	end

	always_comb begin
		npcOp = npcSeq;
		if (isBeq | isBne) npcOp = npcBranch;
		else if (isJ | isJal) npcOp = npcJump;
		else if (isJr) npcOp = npcJumpReg;
	end

	always_comb begin
		cmpOp = cmpEq;
		if (isBne) cmpOp = cmpNe;
		else if (isMovz) cmpOp = cmpRtZero;
	end

	always_comb begin
		beOp = beNone;
		if (isSw) beOp = beWord;
		else if (isSh) beOp = beHalf;
		else if (isSb) beOp = beByte;
		deOp = deNone;
		if (isLw) deOp = deWord;
		else if (isLb) deOp = deByte;
		else if (isLh) deOp = deHalf;
	end

	always_comb begin
		mduOp = mduNone;
		if (isMult) mduOp = mduMult;
		else if (isMultu) mduOp = mduMultu;
		else if (isDiv) mduOp = mduDiv;
		else if (isDivu) mduOp = mduDivu;
		else if (isMfhi) mduOp = mduMfhi;
		else if (isMflo) mduOp = mduMflo;
		else if (isMthi) mduOp = mduMthi;
		else if (isMtlo) mduOp = mduMtlo;
	end

endmodule

`default_nettype wire

// ==== cmp.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmp (
	input wire mipsIsaPkg::wordT a, // rs
	input wire mipsIsaPkg::wordT b, // rt
	input wire ctrlPkg::cmpOpT cmpOp,
	input wire logic isBranch,
	output logic judge,
	output logic branchTaken
);
	import ctrlPkg::*;

	always_comb begin
		case (cmpOp)
			cmpEq: judge = (a == b);
			cmpNe: judge = (a != b);
			cmpRtZero: judge = (b == '0); // movz test
			default: judge = 1'b0;
		endcase
	end

	// Only beq and bne redirect the PC
	assign branchTaken = judge & isBranch;

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
	input wire mipsIsaPkg::wordT a,
	input wire mipsIsaPkg::wordT b,
	input wire mipsIsaPkg::imm16T imm,
	input wire logic extOp,
	input wire logic aluSrc,
	input wire ctrlPkg::aluCtrlT aluCtrl,
	output mipsIsaPkg::wordT y
);
	import mipsIsaPkg::*;
	import ctrlPkg::*;

	wordT extImm;
	wordT opB;

	// Sign or zero extension
	assign extImm = extOp ? {{(wordW-immW){imm[immW-1]}}, imm} : {{(wordW-immW){1'b0}}, imm};
	assign opB = aluSrc ? extImm : b;

	always_comb begin
		y = '0;
		case (aluCtrl)
			aluAdd: y = a + opB;
			aluSub: y = a - opB;
			aluOr: y = a | opB;
			aluAnd: y = a & opB;
			aluLui: y = {imm, {(wordW-immW){1'b0}}}; // Upper half
			aluSlt: y[0] = ($signed(a) < $signed(opB));
			aluSltu: y[0] = (a < opB);
			aluPassA: y = a; // movz
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== mdu.sv ====
`timescale 1ns/10ps
`default_nettype none

module mdu #(
	parameter int multCycles = 5,
	parameter int divCycles = 10
) (
	input wire logic clk,
	input wire logic rstN,
	input wire mipsIsaPkg::wordT a, // rs
	input wire mipsIsaPkg::wordT b, // rt
	input wire logic start,
	input wire logic selMdu,
	input wire ctrlPkg::mduOpT mduOp,
	input wire mipsIsaPkg::wordT aluResult,
	output mipsIsaPkg::wordT result,
	output logic stall
);
	import mipsIsaPkg::*;
	import ctrlPkg::*;

	localparam int maxCycles = (multCycles > divCycles) ? multCycles : divCycles;
	localparam int cntW = $clog2(maxCycles + 1);

	mduStateT state;
	logic [cntW-1:0] cnt;
	logic busy;
	logic isMul;
	wordT hi, lo;
	wordT opA, opB;
	mduOpT curOp;
	logic [2*wordW-1:0] prodS, prodU;
	wordT quoS, remS, quoU, remU;

	assign busy = (state == mduRun);
	assign stall = busy && (mduOp != mduNone);
	assign isMul = (mduOp == mduMult) || (mduOp == mduMultu);

	// Arithmetic on the latched operands
	assign prodS = $signed({{wordW{opA[wordW-1]}}, opA})
		* $signed({{wordW{opB[wordW-1]}}, opB});
	assign prodU = {{wordW{1'b0}}, opA} * {{wordW{1'b0}}, opB};
	assign quoS = $signed(opA) / $signed(opB);
	assign remS = $signed(opA) % $signed(opB);
	assign quoU = opA / opB;
	assign remU = opA % opB;

	// Operand latch on an accepted start
	always_ff @(posedge clk) begin
		if (state == mduIdle && start) begin
			opA <= a;
			opB <= b;
			curOp <= mduOp;
		end
	end

	//////////////////////////////
	// Latency counter and HI/LO
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= mduIdle;
			cnt <= '0;
			hi <= '0;
			lo <= '0;
		end else begin
			case (state)
				mduIdle: begin
					if (start) begin // Never stalled while idle
						state <= mduRun;
						cnt <= isMul ? cntW'(multCycles - 1) : cntW'(divCycles - 1);
					end
				end
				mduRun: begin
					if (cnt == '0) begin
						state <= mduIdle;
						case (curOp)
							mduMult: {hi, lo} <= prodS;
							mduMultu: {hi, lo} <= prodU;
							mduDiv: if (opB != '0) {hi, lo} <= {remS, quoS};
							mduDivu: if (opB != '0) {hi, lo} <= {remU, quoU};
							default: ;
						endcase
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= mduIdle;
			endcase
			// Moves stall behind a running op
			if (!stall && mduOp == mduMthi) hi <= a;
			if (!stall && mduOp == mduMtlo) lo <= a;
		end
	end

	assign result = selMdu ? ((mduOp == mduMfhi) ? hi : lo) : aluResult;

endmodule

`default_nettype wire

// ==== execCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module execCore #(
	parameter int multCycles = 5,
	parameter int divCycles = 10
) (
	input wire logic clk,
	input wire logic rstN,
	input wire mipsIsaPkg::wordT instr,
	input wire mipsIsaPkg::wordT rsData,
	input wire mipsIsaPkg::wordT rtData,
	output mipsIsaPkg::wordT result,
	output logic regWrite,
	output ctrlPkg::regDstT regDst,
	output logic memWrite,
	output ctrlPkg::memtoRegT memtoReg,
	output ctrlPkg::beOpT beOp,
	output ctrlPkg::deOpT deOp,
	output ctrlPkg::npcOpT npcOp,
	output logic branchTaken,
	output logic stall
);
	import mipsIsaPkg::*;
	import ctrlPkg::*;

	opcodeT op;
	funcT func;
	imm16T imm;
	logic judge, isBranch;
	logic extOp, aluSrc, start, selMdu;
	aluCtrlT aluCtrl;
	cmpOpT cmpOp;
	mduOpT mduOp;
	wordT aluResult;

	// Instruction fields
	assign op = instr[wordW-1 -: opW];
	assign func = instr[funcW-1:0];
	assign imm = instr[immW-1:0];
	assign isBranch = (npcOp == npcBranch);

	ctrl ctrl0 (
		.op(op), .func(func), .judge(judge),
		.regDst(regDst), .regWrite(regWrite), .extOp(extOp), .aluSrc(aluSrc),
		.aluCtrl(aluCtrl), .memWrite(memWrite), .memtoReg(memtoReg), .npcOp(npcOp),
		.cmpOp(cmpOp), .beOp(beOp), .deOp(deOp), .start(start), .selMdu(selMdu),
		.mduOp(mduOp)
	);

	cmp cmp0 (
		.a(rsData), .b(rtData), .cmpOp(cmpOp), .isBranch(isBranch),
		.judge(judge), .branchTaken(branchTaken)
	);

	alu alu0 (
		.a(rsData), .b(rtData), .imm(imm), .extOp(extOp), .aluSrc(aluSrc),
		.aluCtrl(aluCtrl), .y(aluResult)
	);

	// Also muxes the stage result
	mdu #(.multCycles(multCycles), .divCycles(divCycles)) mdu0 (
		.clk(clk), .rstN(rstN), .a(rsData), .b(rtData), .start(start),
		.selMdu(selMdu), .mduOp(mduOp), .aluResult(aluResult),
		.result(result), .stall(stall)
	);

endmodule

`default_nettype wire

// ==== tbClk.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbClk #(
	parameter int period = 40,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Release on a falling edge, away from the DUT flops
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tbExecCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbExecCore;
	import mipsIsaPkg::*;
	import ctrlPkg::*;

	localparam int multCycles = 5;
	localparam int divCycles = 10;
	localparam int period = 40;
	localparam int numAlu = 40;
	localparam int mduRounds = 3;
	// Instructions issued over all sections
	localparam int numTests = 2 + numAlu + 12 + 7 + 4 + 12 * mduRounds + 14;

	logic clk;
	logic rstN;
	wordT instr, rsData, rtData;
	wordT result;
	logic regWrite, memWrite, branchTaken, stall;
	regDstT regDst;
	memtoRegT memtoReg;
	beOpT beOp;
	deOpT deOp;
	npcOpT npcOp;

	int seed;
	string curName;
	logic checkOn;
	wordT hiRef, loRef; // HI/LO model
	wordT expResult;
	logic expChk, expRegWrite, expMemWrite, expBranch, expUsesMdu;
	regDstT expRegDst;
	memtoRegT expMemtoReg;
	beOpT expBeOp;
	deOpT expDeOp;
	npcOpT expNpcOp;

	tbClk #(.period(period), .resetCycles(2)) clk0 (.clk(clk), .rstN(rstN));

	execCore #(.multCycles(multCycles), .divCycles(divCycles)) dut0 (
		.clk(clk), .rstN(rstN), .instr(instr), .rsData(rsData), .rtData(rtData),
		.result(result), .regWrite(regWrite), .regDst(regDst), .memWrite(memWrite),
		.memtoReg(memtoReg), .beOp(beOp), .deOp(deOp), .npcOp(npcOp),
		.branchTaken(branchTaken), .stall(stall)
	);

	//////////////////////////////
	// Error handling and compare tasks
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(input string what, input wordT exp, input wordT act);
		if (act !== exp) begin
			$display("[FAIL] %s: %s expected %h actual %h", curName, what, exp, act);
			abortRun("word mismatch");
		end
	endtask

	task automatic checkBit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: %s expected %b actual %b", curName, what, exp, act);
			abortRun("bit mismatch");
		end
	endtask

	task automatic checkCtrl(input regDstT eDst, input regDstT aDst,
		input memtoRegT eWb, input memtoRegT aWb, input beOpT eBe, input beOpT aBe,
		input deOpT eDe, input deOpT aDe, input npcOpT eNpc, input npcOpT aNpc);
		if ({aDst, aWb, aBe, aDe, aNpc} !== {eDst, eWb, eBe, eDe, eNpc}) begin
			$display("[FAIL] %s: regDst/memtoReg/beOp/deOp/npcOp expected %0d/%0d/%0d/%0d/%0d",
				curName, eDst, eWb, eBe, eDe, eNpc);
			$display("       actual %0d/%0d/%0d/%0d/%0d", aDst, aWb, aBe, aDe, aNpc);
			abortRun("control field mismatch");
		end
	endtask

	//////////////////////////////
	// Reference model
	function automatic wordT refResult(input wordT ins, input wordT rs, input wordT rt,
		input wordT hiM, input wordT loM, output logic chk, output logic rw,
		output regDstT dst, output logic mw, output memtoRegT wb, output beOpT be,
		output deOpT de, output npcOpT npc, output logic taken, output logic usesMdu);
		opcodeT o;
		funcT fn;
		wordT sImm, zImm, res;
		o = ins[31:26];
		fn = ins[5:0];
		sImm = {{16{ins[15]}}, ins[15:0]};
		zImm = {16'h0000, ins[15:0]};
		res = '0;
		chk = 1'b0;
		rw = 1'b0;
		dst = dstRt;
		mw = 1'b0;
		wb = wbAlu;
		be = beNone;
		de = deNone;
		npc = npcSeq;
		taken = 1'b0;
		usesMdu = 1'b0;
		if (o == opR) begin
			chk = 1'b1;
			rw = 1'b1;
			dst = dstRd;
			case (fn)
				fnAdd: res = rs + rt;
				fnSub: res = rs - rt;
				fnAnd: res = rs & rt;
				fnOr: res = rs | rt;
				fnSlt: res = {31'b0, $signed(rs) < $signed(rt)};
				fnSltu: res = {31'b0, rs < rt};
				fnMovz: begin
					res = rs;
					rw = (rt == '0); // Write only on zero rt
				end
				fnMfhi: begin
					res = hiM;
					usesMdu = 1'b1;
				end
				fnMflo: begin
					res = loM;
					usesMdu = 1'b1;
				end
				default: begin // jr, mult/div, moves, unknown
					chk = 1'b0;
					rw = 1'b0;
					dst = dstRt;
					npc = (fn == fnJr) ? npcJumpReg : npcSeq;
					usesMdu = (fn == fnMult) || (fn == fnMultu) || (fn == fnDiv)
						|| (fn == fnDivu) || (fn == fnMthi) || (fn == fnMtlo);
				end
			endcase
		end else begin
			case (o)
				opLw, opLb, opLh: begin
					res = rs + sImm; // Address
					chk = 1'b1;
					rw = 1'b1;
					wb = wbMem;
					de = (o == opLw) ? deWord : ((o == opLb) ? deByte : deHalf);
				end
				opSw, opSb, opSh: begin
					res = rs + sImm;
					chk = 1'b1;
					mw = 1'b1;
					be = (o == opSw) ? beWord : ((o == opSb) ? beByte : beHalf);
				end
				opOri, opAddi, opAndi, opLui: begin
					chk = 1'b1;
					rw = 1'b1;
					case (o)
						opOri: res = rs | zImm;
						opAddi: res = rs + sImm;
						opAndi: res = rs & zImm;
						default: res = {ins[15:0], 16'h0000};
					endcase
				end
				opBeq: begin
					npc = npcBranch;
					taken = (rs == rt);
				end
				opBne: begin
					npc = npcBranch;
					taken = (rs != rt);
				end
				opJ: npc = npcJump;
				opJal: begin
					npc = npcJump;
					rw = 1'b1;
					dst = dstRa;
					wb = wbPc;
				end
				default: ;
			endcase
		end
		return res;
	endfunction

	// HI/LO update once an instruction is accepted
	task automatic updateHiLo(input wordT ins, input wordT rs, input wordT rt);
		logic signed [63:0] sa, sb, ps;
		logic [63:0] pu;
		sa = {{32{rs[31]}}, rs};
		sb = {{32{rt[31]}}, rt};
		ps = sa * sb;
		pu = {32'h0, rs} * {32'h0, rt};
		if (ins[31:26] == opR) begin
			case (ins[5:0])
				fnMult: {hiRef, loRef} = ps;
				fnMultu: {hiRef, loRef} = pu;
				fnDiv: if (rt != '0) begin
					loRef = $signed(rs) / $signed(rt);
					hiRef = $signed(rs) % $signed(rt);
				end
				fnDivu: if (rt != '0) begin
					loRef = rs / rt;
					hiRef = rs % rt;
				end
				fnMthi: hiRef = rs;
				fnMtlo: loRef = rs;
				default: ;
			endcase
		end
	endtask

	//////////////////////////////
	// Stimulus helpers
	function automatic wordT rInstr(input funcT fn);
		return {opR, 5'd1, 5'd2, 5'd3, 5'd0, fn};
	endfunction

	function automatic wordT iInstr(input opcodeT o, input imm16T imm);
		return {o, 5'd1, 5'd2, imm};
	endfunction

	function automatic wordT jInstr(input opcodeT o);
		return {o, 26'h0000100};
	endfunction

	// Holds the instruction until stall is low
	task automatic issue(input string name, input wordT ins, input wordT rs, input wordT rt);
		@(negedge clk);
		instr = ins;
		rsData = rs;
		rtData = rt;
		curName = name;
		expResult = refResult(ins, rs, rt, hiRef, loRef, expChk, expRegWrite, expRegDst,
			expMemWrite, expMemtoReg, expBeOp, expDeOp, expNpcOp, expBranch, expUsesMdu);
		checkOn = 1'b1;
		#10;
		while (stall) begin
			@(negedge clk);
			#10;
		end
		updateHiLo(ins, rs, rt);
	endtask

	// Compare just before each rising edge
	always @(negedge clk) begin
		#(period / 2 - 1);
		if (checkOn) begin
			if (stall && !expUsesMdu)
				abortRun("stall is high for an instruction that does not use the MDU");
			checkBit("regWrite", expRegWrite, regWrite);
			checkBit("memWrite", expMemWrite, memWrite);
			checkBit("branchTaken", expBranch, branchTaken);
			checkCtrl(expRegDst, regDst, expMemtoReg, memtoReg, expBeOp, beOp,
				expDeOp, deOp, expNpcOp, npcOp);
			if (expChk && !stall) checkWord("result", expResult, result);
		end
	end

	initial begin
		#(numTests * (divCycles + 4) * period);
		abortRun("Watchdog expired before all tests finished");
	end

	//////////////////////////////
	// Test sequence
	initial begin
		int k;
		wordT a, b;
		imm16T imm;
		seed = 7;
		instr = '0;
		rsData = '0;
		rtData = '0;
		checkOn = 1'b0;
		hiRef = '0;
		loRef = '0;
		curName = "after reset";
		@(posedge rstN);
		#1;
		checkBit("stall", 1'b0, stall);
		issue("mfhi after reset", rInstr(fnMfhi), '0, '0);
		issue("mflo after reset", rInstr(fnMflo), '0, '0);

		for (int i = 0; i < numAlu; i++) begin
			k = $unsigned($random(seed)) % 10;
			a = $random(seed);
			b = $random(seed);
			imm = 16'($random(seed));
			case (k)
				0: issue("add", rInstr(fnAdd), a, b);
				1: issue("sub", rInstr(fnSub), a, b);
				2: issue("and", rInstr(fnAnd), a, b);
				3: issue("or", rInstr(fnOr), a, b);
				4: issue("slt", rInstr(fnSlt), a, b);
				5: issue("sltu", rInstr(fnSltu), a, b);
				6: issue("ori", iInstr(opOri, imm), a, b);
				7: issue("addi", iInstr(opAddi, imm), a, b);
				8: issue("andi", iInstr(opAndi, imm), a, b);
				default: issue("lui", iInstr(opLui, imm), a, b);
			endcase
		end

		for (int i = 0; i < 2; i++) begin
			a = $random(seed);
			b = $random(seed);
			imm = 16'($random(seed));
			issue("lw", iInstr(opLw, imm), a, b);
			issue("lb", iInstr(opLb, imm), a, b);
			issue("lh", iInstr(opLh, imm), a, b);
			issue("sw", iInstr(opSw, imm), a, b);
			issue("sb", iInstr(opSb, imm), a, b);
			issue("sh", iInstr(opSh, imm), a, b);
		end

		a = $random(seed);
		b = a ^ 32'h0000_0001; // Differs from a
		issue("beq equal", iInstr(opBeq, 16'h0004), a, a);
		issue("beq unequal", iInstr(opBeq, 16'h0004), a, b);
		issue("bne equal", iInstr(opBne, 16'hfffc), a, a);
		issue("bne unequal", iInstr(opBne, 16'hfffc), a, b);
		issue("j", jInstr(opJ), a, b);
		issue("jal", jInstr(opJal), a, b);
		issue("jr", rInstr(fnJr), a, b);

		issue("movz rt zero", rInstr(fnMovz), a, '0);
		issue("movz rt nonzero", rInstr(fnMovz), a, b | 32'h1);
		a = $random(seed);
		b = $random(seed);
		issue("movz random rt", rInstr(fnMovz), a, b | 32'h8000_0000);
		issue("movz rt zero again", rInstr(fnMovz), b, '0);

		for (int r = 0; r < mduRounds; r++) begin
			a = $random(seed);
			b = $random(seed);
			issue("mult", rInstr(fnMult), a, b);
			issue("mfhi after mult", rInstr(fnMfhi), '0, '0);
			issue("mflo after mult", rInstr(fnMflo), '0, '0);
			issue("multu", rInstr(fnMultu), a, b);
			issue("mfhi after multu", rInstr(fnMfhi), '0, '0);
			issue("mflo after multu", rInstr(fnMflo), '0, '0);
			issue("div", rInstr(fnDiv), a, b >>> r);
			issue("mfhi after div", rInstr(fnMfhi), '0, '0);
			issue("mflo after div", rInstr(fnMflo), '0, '0);
			issue("divu", rInstr(fnDivu), a, b >> (4 * r));
			issue("mfhi after divu", rInstr(fnMfhi), '0, '0);
			issue("mflo after divu", rInstr(fnMflo), '0, '0);
		end

		a = $random(seed);
		b = $random(seed);
		issue("mthi", rInstr(fnMthi), a, b);
		issue("mfhi after mthi", rInstr(fnMfhi), '0, '0);
		issue("mtlo", rInstr(fnMtlo), b, a);
		issue("mflo after mtlo", rInstr(fnMflo), '0, '0);
		issue("div by zero", rInstr(fnDiv), a, '0); // HI/LO stay
		issue("mfhi after div by zero", rInstr(fnMfhi), '0, '0);
		issue("mflo after div by zero", rInstr(fnMflo), '0, '0);
		issue("divu by zero", rInstr(fnDivu), b, '0);
		issue("mfhi after divu by zero", rInstr(fnMfhi), '0, '0);
		issue("mflo after divu by zero", rInstr(fnMflo), '0, '0);
		issue("mult before mthi", rInstr(fnMult), a, b);
		issue("add behind mult", rInstr(fnAdd), a, b); // No stall while busy
		issue("mthi behind mult", rInstr(fnMthi), b, a);
		issue("mfhi after held mthi", rInstr(fnMfhi), '0, '0);

		@(negedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
mipsIsaPkg.sv
ctrlPkg.sv
ctrl.sv
cmp.sv
alu.sv
mdu.sv
execCore.sv
tbClk.sv
tbExecCore.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the execCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tbExecCore -f src.f -o simExecCore
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/simExecCore
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
